// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - source/rv_pkg.sv
  - source/rv_fetch.sv
  - source/rv_decoder.sv
  - source/rv_regfile.sv
  - source/rv_execute.sv
  - source/rv_lsu.sv
  - source/rv_bus_arbiter.sv
  - source/rv_core.sv
  - target: test
    files:
      - test/rv_core_mem.sv
      - test/rv_core_tb.sv

// ==== rv_core.f ====
source/rv_pkg.sv
source/rv_fetch.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_lsu.sv
source/rv_bus_arbiter.sv
source/rv_core.sv
test/rv_core_mem.sv
test/rv_core_tb.sv

// ==== source/rv_bus_arbiter.sv ====
`timescale 1ns/1ns

module rv_bus_arbiter (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          if_req,
    input  rv_pkg::word_t if_addr,
    output logic          if_ack,
    output rv_pkg::word_t if_rdata,
    input  logic          ls_req,
    input  rv_pkg::word_t ls_addr,
    input  logic          ls_we,
    input  rv_pkg::word_t ls_wdata,
    output logic          ls_ack,
    output rv_pkg::word_t ls_rdata,
    output logic          mem_req,
    output rv_pkg::word_t mem_addr,
    output logic          mem_we,
    output rv_pkg::word_t mem_wdata,
    input  logic          mem_ack,
    input  rv_pkg::word_t mem_rdata
);
    import rv_pkg::*;

    logic busy;
    logic own_ls;
    logic owner_req;
    logic idle;
    logic sel_ls;

    assign owner_req = own_ls ? ls_req : if_req;
    // owner done once both req and ack are low
    assign idle   = !busy || (!owner_req && !mem_ack);
    assign sel_ls = idle ? ls_req : own_ls;  // load/store wins a tie

    assign mem_req   = sel_ls ? ls_req : if_req;
    assign mem_addr  = sel_ls ? ls_addr : if_addr;
    assign mem_we    = sel_ls && ls_we;
    assign mem_wdata = sel_ls ? ls_wdata : '0;

    assign if_ack   = mem_ack && !sel_ls;
    assign ls_ack   = mem_ack && sel_ls;
    assign if_rdata = sel_ls ? '0 : mem_rdata;
    assign ls_rdata = sel_ls ? mem_rdata : '0;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy   <= 1'b0;
            own_ls <= 1'b0;
        end
        else if (idle)
        begin
            busy   <= ls_req || if_req;
            own_ls <= sel_ls;
        end
    end

endmodule

// ==== source/rv_core.sv ====
`timescale 1ns/1ns

module rv_core #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          rst_n,
    output logic          mem_req,
    output rv_pkg::word_t mem_addr,
    output logic          mem_we,
    output rv_pkg::word_t mem_wdata,
    input  logic          mem_ack,
    input  rv_pkg::word_t mem_rdata,
    output rv_pkg::word_t pc,
    output rv_pkg::word_t inst,
    output logic          retire
);
    import rv_pkg::*;

    word_t   next_pc;
    logic    if_req;
    word_t   if_addr;
    logic    if_ack;
    word_t   if_rdata;
    logic    inst_valid;
    logic    finish;
    word_t   imm;
    a_sel_t  a_sel;
    b_sel_t  b_sel;
    alu_op_t alu_op;
    branch_t branch;
    logic    jump;
    wb_sel_t wb_sel;
    logic    reg_we;
    logic    mem_rd;
    logic    mem_wr;
    word_t   rs1_data;
    word_t   rs2_data;
    word_t   alu_out;
    word_t   rd_data;
    word_t   load_data;
    logic    ls_req;
    word_t   ls_addr;
    logic    ls_we;
    word_t   ls_wdata;
    logic    ls_ack;
    word_t   ls_rdata;

    assign retire = finish;

    rv_fetch #(
        .RESET_PC(RESET_PC)
    ) i_rv_fetch (
        .clk(clk),
        .rst_n(rst_n),
        .finish(finish),
        .next_pc(next_pc),
        .if_req(if_req),
        .if_addr(if_addr),
        .if_ack(if_ack),
        .if_rdata(if_rdata),
        .pc(pc),
        .inst(inst),
        .inst_valid(inst_valid)
    );

    rv_decoder i_rv_decoder (
        .inst(inst),
        .imm(imm),
        .a_sel(a_sel),
        .b_sel(b_sel),
        .alu_op(alu_op),
        .branch(branch),
        .jump(jump),
        .wb_sel(wb_sel),
        .reg_we(reg_we),
        .mem_rd(mem_rd),
        .mem_wr(mem_wr)
    );

    rv_regfile i_rv_regfile (
        .clk(clk),
        .rst_n(rst_n),
        .rs1_addr(inst[19:15]),
        .rs2_addr(inst[24:20]),
        .rd_addr(inst[11:7]),
        .rd_data(rd_data),
        .reg_we(reg_we),
        .finish(finish),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

    rv_execute i_rv_execute (
        .pc(pc),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .imm(imm),
        .a_sel(a_sel),
        .b_sel(b_sel),
        .alu_op(alu_op),
        .branch(branch),
        .jump(jump),
        .wb_sel(wb_sel),
        .load_data(load_data),
        .alu_out(alu_out),
        .next_pc(next_pc),
        .rd_data(rd_data)
    );

    rv_lsu i_rv_lsu (
        .clk(clk),
        .rst_n(rst_n),
        .inst_valid(inst_valid),
        .mem_rd(mem_rd),
        .mem_wr(mem_wr),
        .addr(alu_out),
        .wdata(rs2_data),
        .ls_req(ls_req),
        .ls_addr(ls_addr),
        .ls_we(ls_we),
        .ls_wdata(ls_wdata),
        .ls_ack(ls_ack),
        .ls_rdata(ls_rdata),
        .load_data(load_data),
        .finish(finish)
    );

    rv_bus_arbiter i_rv_bus_arbiter (
        .clk(clk),
        .rst_n(rst_n),
        .if_req(if_req),
        .if_addr(if_addr),
        .if_ack(if_ack),
        .if_rdata(if_rdata),
        .ls_req(ls_req),
        .ls_addr(ls_addr),
        .ls_we(ls_we),
        .ls_wdata(ls_wdata),
        .ls_ack(ls_ack),
        .ls_rdata(ls_rdata),
        .mem_req(mem_req),
        .mem_addr(mem_addr),
        .mem_we(mem_we),
        .mem_wdata(mem_wdata),
        .mem_ack(mem_ack),
        .mem_rdata(mem_rdata)
    );

endmodule

// ==== source/rv_decoder.sv ====
`timescale 1ns/1ns

module rv_decoder (
    input  rv_pkg::word_t   inst,
    output rv_pkg::word_t   imm,
    output rv_pkg::a_sel_t  a_sel,
    output rv_pkg::b_sel_t  b_sel,
    output rv_pkg::alu_op_t alu_op,
    output rv_pkg::branch_t branch,
    output logic            jump,
    output rv_pkg::wb_sel_t wb_sel,
    output logic            reg_we,
    output logic            mem_rd,
    output logic            mem_wr
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    always_comb
    begin
        imm    = '0;
        a_sel  = A_RS1;
        b_sel  = B_RS2;
        alu_op = ALU_ADD;
        branch = BR_NONE;
        jump   = 1'b0;
        wb_sel = WB_ALU;
        reg_we = 1'b0;
        mem_rd = 1'b0;
        mem_wr = 1'b0;
        case (opcode)
            OPC_OP:
            begin
                reg_we = 1'b1;
                case (funct3)
                    3'b000:  alu_op = inst[30] ? ALU_SUB : ALU_ADD;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: reg_we = 1'b0;  // shifts not kept
                endcase
            end
            OPC_OP_IMM:
            begin
                imm    = {{20{inst[31]}}, inst[31:20]};
                b_sel  = B_IMM;
                reg_we = (funct3 == 3'b000);  // addi only
            end
            OPC_LUI:
            begin
                imm    = {inst[31:12], 12'b0};
                b_sel  = B_IMM;
                alu_op = ALU_PASS_B;
                reg_we = 1'b1;
            end
            OPC_LOAD:
            begin
                imm    = {{20{inst[31]}}, inst[31:20]};
                b_sel  = B_IMM;
                mem_rd = 1'b1;
                wb_sel = WB_MEM;
                reg_we = 1'b1;
            end
            OPC_STORE:
            begin
                imm    = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                b_sel  = B_IMM;
                mem_wr = 1'b1;
            end
            OPC_BRANCH:
            begin
                imm   = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                a_sel = A_PC;  // alu forms the target
                b_sel = B_IMM;
                case (funct3)
                    3'b000:  branch = BR_EQ;
                    3'b001:  branch = BR_NE;
                    default: branch = BR_NONE;
                endcase
            end
            OPC_JAL:
            begin
                imm    = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                a_sel  = A_PC;
                b_sel  = B_IMM;
                jump   = 1'b1;
                wb_sel = WB_PC4;  // link
                reg_we = 1'b1;
            end
            default: ;  // no-op
        endcase
    end

endmodule

// ==== source/rv_execute.sv ====
`timescale 1ns/1ns

module rv_execute (
    input  rv_pkg::word_t   pc,
    input  rv_pkg::word_t   rs1_data,
    input  rv_pkg::word_t   rs2_data,
    input  rv_pkg::word_t   imm,
    input  rv_pkg::a_sel_t  a_sel,
    input  rv_pkg::b_sel_t  b_sel,
    input  rv_pkg::alu_op_t alu_op,
    input  rv_pkg::branch_t branch,
    input  logic            jump,
    input  rv_pkg::wb_sel_t wb_sel,
    input  rv_pkg::word_t   load_data,
    output rv_pkg::word_t   alu_out,
    output rv_pkg::word_t   next_pc,
    output rv_pkg::word_t   rd_data
);
    import rv_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t pc_plus4;
    logic  taken;

    assign op_a     = (a_sel == A_PC) ? pc : rs1_data;
    assign op_b     = (b_sel == B_IMM) ? imm : rs2_data;
    assign pc_plus4 = pc + 32'd4;

    always_comb
    begin
        case (alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    always_comb
    begin
        case (branch)
            BR_EQ:   taken = (rs1_data == rs2_data);
            BR_NE:   taken = (rs1_data != rs2_data);
            default: taken = 1'b0;
        endcase
    end

    // branch and jal set the alu to pc + imm
    assign next_pc = (taken || jump) ? alu_out : pc_plus4;

    always_comb
    begin
        case (wb_sel)
            WB_PC4:  rd_data = pc_plus4;
            WB_MEM:  rd_data = load_data;
            default: rd_data = alu_out;
        endcase
    end

endmodule

// ==== source/rv_fetch.sv ====
`timescale 1ns/1ns

module rv_fetch #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          finish,
    input  rv_pkg::word_t next_pc,
    output logic          if_req,
    output rv_pkg::word_t if_addr,
    input  logic          if_ack,
    input  rv_pkg::word_t if_rdata,
    output rv_pkg::word_t pc,
    output rv_pkg::word_t inst,
    output logic          inst_valid
);
    import rv_pkg::*;

    typedef enum logic [1:0] {F_REQ, F_REL, F_HOLD} fetch_state_t;

    fetch_state_t state;

    assign if_addr = pc;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state      <= F_REQ;
            if_req     <= 1'b0;
            inst_valid <= 1'b0;
            pc         <= RESET_PC;
        end
        else
        begin
            case (state)
                F_REQ:
                begin
                    if (!if_req && !if_ack)
                        if_req <= 1'b1;  // first fetch out of reset
                    else if (if_req && if_ack)
                    begin
                        if_req <= 1'b0;
                        state  <= F_REL;
                    end
                end
                F_REL:
                begin
                    if (!if_ack)
                    begin
                        inst_valid <= 1'b1;
                        state      <= F_HOLD;
                    end
                end
                default:
                begin
                    if (finish)
                    begin
                        pc         <= next_pc;
                        inst_valid <= 1'b0;
                        if_req     <= 1'b1;  // next fetch
                        state      <= F_REQ;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == F_REQ && if_req && if_ack)
            inst <= if_rdata;
    end

endmodule

// ==== source/rv_lsu.sv ====
`timescale 1ns/1ns

module rv_lsu (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          inst_valid,
    input  logic          mem_rd,
    input  logic          mem_wr,
    input  rv_pkg::word_t addr,
    input  rv_pkg::word_t wdata,
    output logic          ls_req,
    output rv_pkg::word_t ls_addr,
    output logic          ls_we,
    output rv_pkg::word_t ls_wdata,
    input  logic          ls_ack,
    input  rv_pkg::word_t ls_rdata,
    output rv_pkg::word_t load_data,
    output logic          finish
);
    import rv_pkg::*;

    typedef enum logic [1:0] {L_IDLE, L_REQ, L_REL, L_DONE} lsu_state_t;

    lsu_state_t state;
    logic       start;

    assign start  = inst_valid && (mem_rd || mem_wr);
    assign ls_req = (state == L_REQ);
    // non-memory ops retire straight from idle
    assign finish = (state == L_DONE) || (state == L_IDLE && inst_valid && !mem_rd && !mem_wr);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= L_IDLE;
        else
        begin
            case (state)
                L_IDLE:  if (start) state <= L_REQ;
                L_REQ:   if (ls_ack) state <= L_REL;
                L_REL:   if (!ls_ack) state <= L_DONE;  // wait for ack low
                default: state <= L_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == L_IDLE && start)
        begin
            ls_addr  <= addr;
            ls_we    <= mem_wr;
            ls_wdata <= wdata;
        end
        if (state == L_REQ && ls_ack)
            load_data <= ls_rdata;
    end

endmodule

// ==== source/rv_pkg.sv ====
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic        a_sel_t;
    typedef logic        b_sel_t;
    typedef logic [1:0]  wb_sel_t;
    typedef logic [1:0]  branch_t;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLT    = 4'd5;
    localparam alu_op_t ALU_PASS_B = 4'd6;  // lui

    localparam a_sel_t A_RS1 = 1'b0;
    localparam a_sel_t A_PC  = 1'b1;

    localparam b_sel_t B_RS2 = 1'b0;
    localparam b_sel_t B_IMM = 1'b1;

    localparam wb_sel_t WB_ALU = 2'd0;
    localparam wb_sel_t WB_PC4 = 2'd1;
    localparam wb_sel_t WB_MEM = 2'd2;

    localparam branch_t BR_NONE = 2'd0;
    localparam branch_t BR_EQ   = 2'd1;
    localparam branch_t BR_NE   = 2'd2;

    // base opcodes in inst[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

endpackage

// ==== source/rv_regfile.sv ====
`timescale 1ns/1ns

module rv_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::reg_addr_t rd_addr,
    input  rv_pkg::word_t     rd_data,
    input  logic              reg_we,
    input  logic              finish,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);
    import rv_pkg::*;

    word_t regs [0:31];
    logic  we;

    // write only as the instruction retires
    assign we = reg_we && finish && rst_n;

    always_ff @(posedge clk)
    begin
        if (we && rd_addr != '0)
            regs[rd_addr] <= rd_data;
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];  // x0 reads zero
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== test/rv_core_mem.sv ====
`timescale 1ns/1ns

module rv_core_mem (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          req,
    input  rv_pkg::word_t addr,
    input  logic          we,
    input  rv_pkg::word_t wdata,
    output logic          ack,
    output rv_pkg::word_t rdata,
    output logic          proto_err
);
    import rv_pkg::*;

    word_t      mem [0:255];
    logic [2:0] delay_tab [0:255];  // ack delays loaded by the testbench
    logic [7:0] txn_cnt;
    logic [2:0] wait_cnt;
    logic       busy;
    logic       req_q;
    word_t      addr_q;
    logic       we_q;
    word_t      wdata_q;

    task automatic flag_breach(input string why);
        $display("memory model: %s at %0t ns", why, $time);
        proto_err <= 1'b1;
    endtask

    initial
    begin
        ack       = 1'b0;
        rdata     = '0;
        proto_err = 1'b0;
    end

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            ack     <= 1'b0;
            busy    <= 1'b0;
            txn_cnt <= '0;
            req_q   <= 1'b0;
        end
        else
        begin
            req_q   <= req;
            addr_q  <= addr;
            we_q    <= we;
            wdata_q <= wdata;
            if (req && !req_q && ack)
                flag_breach("request raised while ack is still high");
            if (req && req_q && (addr !== addr_q || we !== we_q || wdata !== wdata_q))
                flag_breach("addr, we or wdata changed while request is high");
            if (!req && req_q && !ack)
                flag_breach("request dropped before ack");
            if (req && addr[31:10] != '0)
                flag_breach("access outside the 1 KiB memory");

            if (req && !ack && !busy)
            begin
                busy     <= 1'b1;
                wait_cnt <= delay_tab[txn_cnt];
                txn_cnt  <= txn_cnt + 8'd1;
            end
            else if (busy)
            begin
                if (wait_cnt == '0)
                begin
                    busy  <= 1'b0;
                    ack   <= 1'b1;
                    rdata <= mem[addr[9:2]];
                    if (we)
                        mem[addr[9:2]] <= wdata;
                end
                else
                    wait_cnt <= wait_cnt - 3'd1;
            end
            else if (ack && !req)
                ack <= 1'b0;  // four-phase release
        end
    end

endmodule

// ==== test/rv_core_tb.sv ====
`timescale 1ns/1ns

module rv_core_tb;
    import rv_pkg::*;

    localparam word_t RESET_PC   = 32'h0000_0100;
    localparam int    TIMEOUT    = 200;
    localparam int    NUM_RETIRE = 31;

    logic  clk = 1'b0;
    logic  rst_n = 1'b0;
    logic  mem_req;
    word_t mem_addr;
    logic  mem_we;
    word_t mem_wdata;
    logic  mem_ack;
    word_t mem_rdata;
    word_t pc;
    word_t inst;
    logic  retire;
    logic  proto_err;

    // program table with one row per word in address order
    word_t row_pc [0:63];
    word_t row_inst [0:63];
    logic  row_st [0:63];
    word_t row_st_addr [0:63];
    word_t row_st_data [0:63];
    int    retire_row [0:NUM_RETIRE-1];  // retire order to row
    int    n_rows = 0;

    word_t ret_pc_q [$];
    word_t ret_inst_q [$];
    word_t st_addr_q [$];
    word_t st_data_q [$];
    logic  store_seen = 1'b0;

    always #2 clk = ~clk;

    rv_core #(
        .RESET_PC(RESET_PC)
    ) i_rv_core (
        .clk(clk),
        .rst_n(rst_n),
        .mem_req(mem_req),
        .mem_addr(mem_addr),
        .mem_we(mem_we),
        .mem_wdata(mem_wdata),
        .mem_ack(mem_ack),
        .mem_rdata(mem_rdata),
        .pc(pc),
        .inst(inst),
        .retire(retire)
    );

    rv_core_mem i_rv_core_mem (
        .clk(clk),
        .rst_n(rst_n),
        .req(mem_req),
        .addr(mem_addr),
        .we(mem_we),
        .wdata(mem_wdata),
        .ack(mem_ack),
        .rdata(mem_rdata),
        .proto_err(proto_err)
    );

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_val(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("[FAIL] t=%0t ns %s: got %h, expected %h", $time, name, got, exp);
            stop_with_error("value mismatch");
        end
    endtask

    function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3,
                                     input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};  // sw
    endfunction

    function automatic word_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic word_t j_type(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic add_row(input word_t ins, input int order, input logic st,
                           input word_t st_addr, input word_t st_data);
        row_pc[n_rows]      = RESET_PC + 32'(4 * n_rows);
        row_inst[n_rows]    = ins;
        row_st[n_rows]      = st;
        row_st_addr[n_rows] = st_addr;
        row_st_data[n_rows] = st_data;
        if (order >= 0)
            retire_row[order] = n_rows;
        n_rows++;
    endtask

    task automatic build_program();
        // x1 = 0x6c and x2 = -53
        add_row(i_type(12'h06c, 5'd0, 3'b000, 5'd1, OPC_OP_IMM), 0, 1'b0, 0, 0);
        add_row(s_type(12'h380, 5'd1, 5'd0), 1, 1'b1, 32'h380, 32'h0000_006c);
        add_row(i_type(12'hfcb, 5'd0, 3'b000, 5'd2, OPC_OP_IMM), 2, 1'b0, 0, 0);
        add_row(s_type(12'h384, 5'd2, 5'd0), 3, 1'b1, 32'h384, 32'hffff_ffcb);
        add_row(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 4, 1'b0, 0, 0);  // add
        add_row(s_type(12'h388, 5'd3, 5'd0), 5, 1'b1, 32'h388, 32'h0000_0037);
        add_row(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 6, 1'b0, 0, 0);  // sub
        add_row(s_type(12'h38c, 5'd4, 5'd0), 7, 1'b1, 32'h38c, 32'h0000_00a1);
        add_row(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd5), 8, 1'b0, 0, 0);  // and
        add_row(s_type(12'h390, 5'd5, 5'd0), 9, 1'b1, 32'h390, 32'h0000_0048);
        add_row(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6), 10, 1'b0, 0, 0);  // or
        add_row(s_type(12'h394, 5'd6, 5'd0), 11, 1'b1, 32'h394, 32'hffff_ffef);
        add_row(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd7), 12, 1'b0, 0, 0);  // xor
        add_row(s_type(12'h398, 5'd7, 5'd0), 13, 1'b1, 32'h398, 32'hffff_ffa7);
        add_row(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd8), 14, 1'b0, 0, 0);  // slt x8, x2, x1
        add_row(s_type(12'h39c, 5'd8, 5'd0), 15, 1'b1, 32'h39c, 32'h0000_0001);
        add_row(u_type(20'habcde, 5'd9), 16, 1'b0, 0, 0);
        add_row(s_type(12'h3a0, 5'd9, 5'd0), 17, 1'b1, 32'h3a0, 32'habcd_e000);
        add_row(i_type(12'h300, 5'd0, 3'b010, 5'd10, OPC_LOAD), 18, 1'b0, 0, 0);
        add_row(i_type(12'h304, 5'd0, 3'b010, 5'd11, OPC_LOAD), 19, 1'b0, 0, 0);
        add_row(s_type(12'h3a4, 5'd10, 5'd0), 20, 1'b1, 32'h3a4, 32'h1234_5678);
        add_row(s_type(12'h3a8, 5'd11, 5'd0), 21, 1'b1, 32'h3a8, 32'h8000_0001);
        // both try to write x0
        add_row(i_type(12'h001, 5'd1, 3'b000, 5'd0, OPC_OP_IMM), 22, 1'b0, 0, 0);
        add_row(i_type(12'h300, 5'd0, 3'b010, 5'd0, OPC_LOAD), 23, 1'b0, 0, 0);
        add_row(s_type(12'h3ac, 5'd0, 5'd0), 24, 1'b1, 32'h3ac, 32'h0000_0000);
        add_row(b_type(13'd8, 5'd2, 5'd1, 3'b000), 25, 1'b0, 0, 0);  // beq not taken
        add_row(b_type(13'd8, 5'd10, 5'd10, 3'b000), 26, 1'b0, 0, 0);  // beq taken
        add_row(i_type(12'h001, 5'd0, 3'b000, 5'd12, OPC_OP_IMM), -1, 1'b0, 0, 0);
        add_row(b_type(13'd8, 5'd2, 5'd1, 3'b001), 27, 1'b0, 0, 0);  // bne taken
        add_row(i_type(12'h002, 5'd0, 3'b000, 5'd12, OPC_OP_IMM), -1, 1'b0, 0, 0);
        add_row(j_type(21'd8, 5'd13), 28, 1'b0, 0, 0);
        add_row(i_type(12'h003, 5'd0, 3'b000, 5'd12, OPC_OP_IMM), -1, 1'b0, 0, 0);
        add_row(s_type(12'h3b0, 5'd13, 5'd0), 29, 1'b1, 32'h3b0, RESET_PC + 32'h7c);
        add_row(j_type(21'd0, 5'd0), 30, 1'b0, 0, 0);  // park here
    endtask

    task automatic wait_for_retire();
        int n;
        n = 0;
        while (ret_pc_q.size() == 0 && n < TIMEOUT)
        begin
            @(posedge clk);
            n++;
        end
        if (ret_pc_q.size() == 0)
            stop_with_error("timeout: no instruction retired");
    endtask

    task automatic wait_for_store();
        int n;
        n = 0;
        while (st_addr_q.size() == 0 && n < TIMEOUT)
        begin
            @(posedge clk);
            n++;
        end
        if (st_addr_q.size() == 0)
            stop_with_error("timeout: expected store never reached the memory port");
    endtask

    task automatic wait_for_first_fetch();
        int n;
        n = 0;
        while (mem_req !== 1'b1 && n < TIMEOUT)
        begin
            @(negedge clk);
            check_val("retire", {31'b0, retire}, 32'd0);
            n++;
        end
        if (mem_req !== 1'b1)
            stop_with_error("timeout: no fetch request after reset");
    endtask

    // bus monitor mid-cycle where outputs are settled
    always @(negedge clk)
    begin
        if (rst_n && retire)
        begin
            ret_pc_q.push_back(pc);
            ret_inst_q.push_back(inst);
        end
        if (rst_n && mem_req && mem_ack && mem_we && !store_seen)
        begin
            st_addr_q.push_back(mem_addr);
            st_data_q.push_back(mem_wdata);
        end
        store_seen = mem_req && mem_ack && mem_we;
    end

    always @(posedge clk)
    begin
        if (proto_err === 1'b1)
            stop_with_error("memory port handshake breach");
    end

    initial
    begin
        int    r;
        word_t got_pc;
        word_t got_inst;
        word_t got_addr;
        word_t got_data;

        void'($urandom(32'h8afc2a11));
        for (int i = 0; i < 256; i++)
        begin
            i_rv_core_mem.delay_tab[i] = 3'($urandom_range(5, 0));
            i_rv_core_mem.mem[i] = 32'h5eed_0000 | (i << 2);
        end
        build_program();
        for (int i = 0; i < n_rows; i++)
            i_rv_core_mem.mem[row_pc[i][9:2]] = row_inst[i];
        i_rv_core_mem.mem[32'h300 >> 2] = 32'h1234_5678;
        i_rv_core_mem.mem[32'h304 >> 2] = 32'h8000_0001;

        for (int i = 0; i < 5; i++)
        begin
            @(posedge clk);
            if (i == 4)
                rst_n <= 1'b1;
            @(negedge clk);
            check_val("mem_req", {31'b0, mem_req}, 32'd0);
            check_val("retire", {31'b0, retire}, 32'd0);
        end
        wait_for_first_fetch();
        check_val("mem_addr", mem_addr, RESET_PC);
        check_val("mem_we", {31'b0, mem_we}, 32'd0);

        for (int k = 0; k < NUM_RETIRE; k++)
        begin
            r = retire_row[k];
            wait_for_retire();
            got_pc   = ret_pc_q.pop_front();
            got_inst = ret_inst_q.pop_front();
            check_val("pc", got_pc, row_pc[r]);
            check_val("inst", got_inst, row_inst[r]);
            if (row_st[r])
            begin
                wait_for_store();
                got_addr = st_addr_q.pop_front();
                got_data = st_data_q.pop_front();
                check_val("mem_addr", got_addr, row_st_addr[r]);
                check_val("mem_wdata", got_data, row_st_data[r]);
            end
            else if (st_addr_q.size() != 0)
                stop_with_error("store seen for an instruction that does not store");
        end

        $display("** PASS **");
        $finish;
    end

endmodule
